// ==== design/floo_red_pkg.sv ====
/*
 * Shared constants and types for the collective reduction unit.
 * Route 0 is always the local eject port; NumRoutes is only a default.
 */

package floo_red_pkg;

  // Route count of one mesh router, local port included
  localparam int unsigned NumRoutes = 5;

  // Route indices
  localparam int unsigned Eject = 0;
  localparam int unsigned North = 1;
  localparam int unsigned East  = 2;
  localparam int unsigned South = 3;
  localparam int unsigned West  = 4;

  // Node id holds x and y coordinates
  localparam int unsigned XYWidth = 2;
  localparam int unsigned IdWidth = 2 * XYWidth;

  // Single-flit payload width
  localparam int unsigned DataWidth = 16;

  // Reduction operation carried by every flit
  typedef enum logic [1:0] {
    RED_ADD = 2'd0,
    RED_MIN = 2'd1,
    RED_MAX = 2'd2,
    RED_XOR = 2'd3
  } red_op_e;

  // Output stage of the control block
  typedef enum logic {
    // No result held, join may proceed
    RED_IDLE = 1'b0,
    // Result waiting on the output port
    RED_FULL = 1'b1
  } red_state_e;

endpackage

// ==== design/floo_reduction_arbiter.sv ====
/*
 * Round-robin leader pick among valid routes; needs NumRoutes of 2 or more.
 * The pointer only moves on an accepted reduction.
 */

`timescale 1ns/100ps

module floo_reduction_arbiter #(
  parameter int unsigned NumRoutes = floo_red_pkg::NumRoutes,
  // Width of a route index
  parameter int unsigned SelWidth  = $clog2(NumRoutes)
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic [NumRoutes-1:0] valid_i,
  input  logic                 accept_i,
  output logic [SelWidth-1:0]  leader_sel_o,
  output logic                 leader_valid_o
);

  // Highest priority route for the next pick
  logic [SelWidth-1:0] ptr_q, ptr_d;
  // Candidate index, one bit wider to hold the unwrapped sum
  logic [SelWidth:0]   cand;

  // Walk from the farthest offset back to the pointer
  // The last hit wins, so the nearest valid route at or after ptr_q is taken
  always_comb begin
    leader_sel_o   = ptr_q;
    leader_valid_o = 1'b0;
    cand           = '0;
    for (int unsigned i = NumRoutes; i > 0; i--) begin
      cand = {1'b0, ptr_q} + (SelWidth+1)'(i - 1);
      // Wrap around the route count
      if (cand >= (SelWidth+1)'(NumRoutes)) begin
        cand = cand - (SelWidth+1)'(NumRoutes);
      end
      if (valid_i[cand[SelWidth-1:0]]) begin
        leader_sel_o   = cand[SelWidth-1:0];
        leader_valid_o = 1'b1;
      end
    end
  end

  // Next pointer is the route after the accepted leader
  always_comb begin
    ptr_d = ptr_q;
    if (accept_i) begin
      if (leader_sel_o == SelWidth'(NumRoutes - 1)) begin
        ptr_d = '0;
      end else begin
        ptr_d = leader_sel_o + 1'b1;
      end
    end
  end

  // Pointer starts at route 0
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else begin
      ptr_q <= ptr_d;
    end
  end

endmodule

// ==== design/floo_reduction_sync.sv ====
/*
 * Groups the flits of the leader's stream and joins them in one cycle.
 * The leader's collective mask must include its own route, or it never drains.
 */

`timescale 1ns/100ps

module floo_reduction_sync #(
  parameter int unsigned NumRoutes         = floo_red_pkg::NumRoutes,
  parameter int unsigned IdWidth           = floo_red_pkg::IdWidth,
  // Whether the local port sends its own flit to a local reduction
  parameter bit          RdSupportLoopback = 1'b0,
  parameter int unsigned SelWidth          = $clog2(NumRoutes)
) (
  input  logic [SelWidth-1:0]                 leader_sel_i,
  input  logic [NumRoutes-1:0]                valid_i,
  input  logic [NumRoutes-1:0][IdWidth-1:0]   dst_id_i,
  input  logic [NumRoutes-1:0][NumRoutes-1:0] coll_mask_i,
  input  logic [IdWidth-1:0]                  node_id_i,
  output logic [NumRoutes-1:0]                ready_o,
  output logic [NumRoutes-1:0]                operand_mask_o,
  output logic                                join_valid_o,
  input  logic                                join_ready_i
);

  import floo_red_pkg::*;

  // Header fields of the leader flit
  logic [IdWidth-1:0]   leader_dst;
  logic [NumRoutes-1:0] leader_mask;
  // Leader's reduction ends at this node
  logic                 leader_local;
  // Valid flits of the same stream as the leader
  logic [NumRoutes-1:0] matched;
  // Matched, plus the eject port when it is not expected to send
  logic [NumRoutes-1:0] present;
  // Routes that must contribute
  logic [NumRoutes-1:0] expected;
  logic                 join_fire;

  assign leader_dst   = dst_id_i[leader_sel_i];
  assign leader_mask  = coll_mask_i[leader_sel_i];
  assign leader_local = (leader_dst == node_id_i);

  // Mask only counts when the leader flit is really there
  assign expected = leader_mask & {NumRoutes{valid_i[leader_sel_i]}};

  for (genvar r = 0; r < NumRoutes; r++) begin : gen_route
    // Same stream means same destination and same collective mask
    assign matched[r] = valid_i[r] &&
                        (dst_id_i[r] == leader_dst) &&
                        (coll_mask_i[r] == leader_mask);

    // Without loopback the local endpoint never injects into its own reduction
    if (!RdSupportLoopback && (r == Eject)) begin : gen_no_loopback
      assign present[r] = matched[r] || leader_local;
    end else begin : gen_plain
      assign present[r] = matched[r];
    end
  end

  // Dynamic join over the expected set; an empty set never fires
  assign join_valid_o = (|expected) && (&(present | ~expected));
  assign join_fire    = join_valid_o && join_ready_i;

  // All expected routes are released together
  assign ready_o = expected & {NumRoutes{join_fire}};

  // Routes that really deliver a payload to the ALU
  assign operand_mask_o = expected & matched;

endmodule

// ==== design/floo_reduction_alu.sv ====
/*
 * Combinational reduction over the masked payloads.
 * ADD wraps at DataWidth; MIN and MAX compare unsigned.
 */

`timescale 1ns/100ps

module floo_reduction_alu #(
  parameter int unsigned NumRoutes = floo_red_pkg::NumRoutes,
  parameter int unsigned DataWidth = floo_red_pkg::DataWidth
) (
  input  logic [NumRoutes-1:0][DataWidth-1:0] payload_i,
  input  logic [NumRoutes-1:0]                operand_mask_i,
  input  floo_red_pkg::red_op_e               op_i,
  output logic [DataWidth-1:0]                result_o
);

  import floo_red_pkg::*;

  // Identity element, also the result for an empty mask
  logic [DataWidth-1:0] identity;

  always_comb begin
    case (op_i)
      RED_MIN: identity = '1;
      default: identity = '0;
    endcase
  end

  // Fold the routes in index order; unmasked routes are skipped
  always_comb begin
    result_o = identity;
    for (int unsigned r = 0; r < NumRoutes; r++) begin
      if (operand_mask_i[r]) begin
        case (op_i)
          RED_ADD: begin
            result_o = result_o + payload_i[r];
          end
          RED_MIN: begin
            if (payload_i[r] < result_o) begin
              result_o = payload_i[r];
            end
          end
          RED_MAX: begin
            if (payload_i[r] > result_o) begin
              result_o = payload_i[r];
            end
          end
          default: begin
            // XOR
            result_o = result_o ^ payload_i[r];
          end
        endcase
      end
    end
  end

endmodule

// ==== design/floo_reduction_ctrl.sv ====
/*
 * One-entry output stage for reduction results.
 * join_ready_o depends combinationally on out_ready_i when full.
 */

`timescale 1ns/100ps

module floo_reduction_ctrl #(
  parameter int unsigned IdWidth   = floo_red_pkg::IdWidth,
  parameter int unsigned DataWidth = floo_red_pkg::DataWidth
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  join_valid_i,
  output logic                  join_ready_o,
  input  logic [DataWidth-1:0]  result_i,
  input  logic [IdWidth-1:0]    dst_id_i,
  input  floo_red_pkg::red_op_e op_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [IdWidth-1:0]    out_dst_id_o,
  output floo_red_pkg::red_op_e out_op_o,
  output logic [DataWidth-1:0]  out_data_o
);

  import floo_red_pkg::*;

  red_state_e           state_q, state_d;
  // Result and header of the held reduction
  logic [DataWidth-1:0] data_q;
  logic [IdWidth-1:0]   dst_q;
  red_op_e              op_q;
  // Handshakes on both sides
  logic                 join_fire;
  logic                 out_fire;

  assign out_valid_o = (state_q == RED_FULL);
  assign out_fire    = out_valid_o && out_ready_i;

  // Free when empty, or when the held result leaves this cycle
  assign join_ready_o = (state_q == RED_IDLE) || out_fire;
  assign join_fire    = join_valid_i && join_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RED_IDLE: begin
        if (join_fire) begin
          state_d = RED_FULL;
        end
      end
      RED_FULL: begin
        // Stay full when a new result replaces the one taken
        if (out_fire && !join_fire) begin
          state_d = RED_IDLE;
        end
      end
      default: begin
        state_d = RED_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= RED_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture on the join edge, otherwise hold under back-pressure
  always_ff @(posedge clk_i) begin
    if (join_fire) begin
      data_q <= result_i;
      dst_q  <= dst_id_i;
      op_q   <= op_i;
    end
  end

  assign out_data_o   = data_q;
  assign out_dst_id_o = dst_q;
  assign out_op_o     = op_q;

endmodule

// ==== design/floo_reduction_unit.sv ====
/*
 * Reduction unit of one mesh router, one flit per route and reduction.
 * A result appears one cycle after its inputs are accepted.
 */

`timescale 1ns/100ps

module floo_reduction_unit #(
  parameter int unsigned NumRoutes         = floo_red_pkg::NumRoutes,
  parameter int unsigned IdWidth           = floo_red_pkg::IdWidth,
  parameter int unsigned DataWidth         = floo_red_pkg::DataWidth,
  parameter bit          RdSupportLoopback = 1'b0
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic [IdWidth-1:0]                    node_id_i,
  // Input flits, one per route
  input  logic [NumRoutes-1:0]                  valid_i,
  output logic [NumRoutes-1:0]                  ready_o,
  input  logic [NumRoutes-1:0][IdWidth-1:0]     dst_id_i,
  input  logic [NumRoutes-1:0][NumRoutes-1:0]   coll_mask_i,
  input  floo_red_pkg::red_op_e [NumRoutes-1:0] op_i,
  input  logic [NumRoutes-1:0][DataWidth-1:0]   payload_i,
  // Reduced output flit
  output logic                                  out_valid_o,
  input  logic                                  out_ready_i,
  output logic [IdWidth-1:0]                    out_dst_id_o,
  output floo_red_pkg::red_op_e                 out_op_o,
  output logic [DataWidth-1:0]                  out_data_o
);

  import floo_red_pkg::*;

  localparam int unsigned SelWidth = $clog2(NumRoutes);

  logic [SelWidth-1:0]  leader_sel;
  logic                 leader_valid;
  logic [NumRoutes-1:0] operand_mask;
  logic                 join_valid, join_ready;
  logic                 accept;
  logic [DataWidth-1:0] result;
  // Header fields taken from the leader
  logic [IdWidth-1:0]   leader_dst;
  red_op_e              leader_op;

  assign leader_dst = dst_id_i[leader_sel];
  assign leader_op  = op_i[leader_sel];

  // Pointer moves only when the leader's group is consumed
  assign accept = leader_valid && join_valid && join_ready;

  floo_reduction_arbiter #(
    .NumRoutes      ( NumRoutes    ),
    .SelWidth       ( SelWidth     )
  ) u_arbiter (
    .clk_i          ( clk_i        ),
    .arst_n_i       ( arst_n_i     ),
    .valid_i        ( valid_i      ),
    .accept_i       ( accept       ),
    .leader_sel_o   ( leader_sel   ),
    .leader_valid_o ( leader_valid )
  );

  floo_reduction_sync #(
    .NumRoutes         ( NumRoutes         ),
    .IdWidth           ( IdWidth           ),
    .RdSupportLoopback ( RdSupportLoopback ),
    .SelWidth          ( SelWidth          )
  ) u_sync (
    .leader_sel_i      ( leader_sel        ),
    .valid_i           ( valid_i           ),
    .dst_id_i          ( dst_id_i          ),
    .coll_mask_i       ( coll_mask_i       ),
    .node_id_i         ( node_id_i         ),
    .ready_o           ( ready_o           ),
    .operand_mask_o    ( operand_mask      ),
    .join_valid_o      ( join_valid        ),
    .join_ready_i      ( join_ready        )
  );

  floo_reduction_alu #(
    .NumRoutes      ( NumRoutes    ),
    .DataWidth      ( DataWidth    )
  ) u_alu (
    .payload_i      ( payload_i    ),
    .operand_mask_i ( operand_mask ),
    .op_i           ( leader_op    ),
    .result_o       ( result       )
  );

  floo_reduction_ctrl #(
    .IdWidth      ( IdWidth      ),
    .DataWidth    ( DataWidth    )
  ) u_ctrl (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .join_valid_i ( join_valid   ),
    .join_ready_o ( join_ready   ),
    .result_i     ( result       ),
    .dst_id_i     ( leader_dst   ),
    .op_i         ( leader_op    ),
    .out_valid_o  ( out_valid_o  ),
    .out_ready_i  ( out_ready_i  ),
    .out_dst_id_o ( out_dst_id_o ),
    .out_op_o     ( out_op_o     ),
    .out_data_o   ( out_data_o   )
  );

endmodule

// ==== dv/floo_reduction_assertions.sv ====
/*
 * Handshake properties of the reduction unit, bound into every instance.
 */

`timescale 1ns/100ps

module floo_reduction_assertions #(
  parameter int unsigned NumRoutes = floo_red_pkg::NumRoutes,
  parameter int unsigned IdWidth   = floo_red_pkg::IdWidth,
  parameter int unsigned DataWidth = floo_red_pkg::DataWidth
) (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input logic [NumRoutes-1:0] ready_o,
  input logic                 out_valid_o,
  input logic                 out_ready_i,
  input logic [IdWidth-1:0]   out_dst_id_o,
  input logic [DataWidth-1:0] out_data_o
);

  // Number of property failures so far
  int unsigned fail_count = 0;

  // Output holds while the consumer stalls
  a_out_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && $stable(out_data_o) && $stable(out_dst_id_o))
  ) else begin
    fail_count++;
    $error("output flit changed while stalled");
  end

  // Full and not taken means no input is consumed
  a_no_ready_when_full: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_o && !out_ready_i) |-> (ready_o == '0)
  ) else begin
    fail_count++;
    $error("input consumed while the output register was blocked");
  end

  // First cycle out of reset
  a_ready_low_after_reset: assert property (
    @(posedge clk_i) $rose(arst_n_i) |-> (ready_o == '0)
  ) else begin
    fail_count++;
    $error("ready high in the first cycle after reset");
  end

endmodule

bind floo_reduction_unit floo_reduction_assertions #(
  .NumRoutes    ( NumRoutes    ),
  .IdWidth      ( IdWidth      ),
  .DataWidth    ( DataWidth    )
) u_assertions (
  .clk_i        ( clk_i        ),
  .arst_n_i     ( arst_n_i     ),
  .ready_o      ( ready_o      ),
  .out_valid_o  ( out_valid_o  ),
  .out_ready_i  ( out_ready_i  ),
  .out_dst_id_o ( out_dst_id_o ),
  .out_data_o   ( out_data_o   )
);

// ==== dv/tb_floo_reduction_unit.sv ====
/*
 * Table-driven testbench for the reduction unit at node 4'h5, loopback off.
 * Each route of a group uses the same op, and every group's mask covers its members.
 */

`timescale 1ns/100ps

module tb_floo_reduction_unit;

  import floo_red_pkg::*;

  localparam int unsigned NR         = NumRoutes;
  localparam int unsigned NT         = 8;
  localparam int unsigned RowTimeout = 60;
  localparam int unsigned NoLate     = 15;

  // One stimulus row, route 4 leftmost in every packed field
  typedef struct packed {
    logic [NR-1:0]              vld;
    logic [NR-1:0][IdWidth-1:0] dst;
    logic [NR-1:0][NR-1:0]      mask;
    logic [NR-1:0][1:0]         op;
    logic [3:0]                 late_route;
    logic [3:0]                 late_delay;
    logic [3:0]                 stall;
    logic [3:0]                 exp_outs;
  } row_t;

  logic                         clk;
  logic                         arst_n;
  logic [NR-1:0]                valid;
  logic [NR-1:0]                ready;
  logic [NR-1:0][IdWidth-1:0]   dst_id;
  logic [NR-1:0][NR-1:0]        coll_mask;
  red_op_e [NR-1:0]             op;
  logic [NR-1:0][DataWidth-1:0] payload;
  logic                         out_valid;
  logic                         out_ready;
  logic [IdWidth-1:0]           out_dst_id;
  red_op_e                      out_op;
  logic [DataWidth-1:0]         out_data;

  string                names[NT];
  row_t                 rows[NT];
  int unsigned          n_rows;
  logic [31:0]          rng;
  int unsigned          errors;
  int unsigned          checks;
  int unsigned          assert_fails;
  // Round-robin pointer of the reference arbiter
  int unsigned          rr_ptr;
  // Expected results in the order their groups were consumed
  logic [DataWidth-1:0] exp_data_q[$];
  logic [IdWidth-1:0]   exp_dst_q[$];
  red_op_e              exp_op_q[$];

  floo_reduction_unit #(
    .NumRoutes         ( NR         ),
    .IdWidth           ( IdWidth    ),
    .DataWidth         ( DataWidth  ),
    .RdSupportLoopback ( 1'b0       )
  ) u_floo_reduction_unit (
    .clk_i             ( clk        ),
    .arst_n_i          ( arst_n     ),
    .node_id_i         ( 4'h5       ),
    .valid_i           ( valid      ),
    .ready_o           ( ready      ),
    .dst_id_i          ( dst_id     ),
    .coll_mask_i       ( coll_mask  ),
    .op_i              ( op         ),
    .payload_i         ( payload    ),
    .out_valid_o       ( out_valid  ),
    .out_ready_i       ( out_ready  ),
    .out_dst_id_o      ( out_dst_id ),
    .out_op_o          ( out_op     ),
    .out_data_o        ( out_data   )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Reference reduction, identity start and unsigned compare
  function automatic logic [DataWidth-1:0] reduce_payloads(
    input logic [NR-1:0] members, input red_op_e opc,
    input logic [NR-1:0][DataWidth-1:0] pl);
    logic [DataWidth-1:0] acc;
    acc = (opc == RED_MIN) ? '1 : '0;
    for (int r = 0; r < NR; r++) begin
      if (members[r]) begin
        case (opc)
          RED_ADD: acc = acc + pl[r];
          RED_MIN: acc = (pl[r] < acc) ? pl[r] : acc;
          RED_MAX: acc = (pl[r] > acc) ? pl[r] : acc;
          default: acc = acc ^ pl[r];
        endcase
      end
    end
    return acc;
  endfunction

  // First valid route at or after the pointer
  function automatic int unsigned pick_leader(input logic [NR-1:0] vld, input int unsigned ptr);
    int unsigned idx;
    for (int unsigned k = 0; k < NR; k++) begin
      idx = (ptr + k) % NR;
      if (vld[idx]) begin
        return idx;
      end
    end
    return ptr;
  endfunction

  // Routes of the row that share the lead's destination and mask
  function automatic logic [NR-1:0] group_of(input row_t row, input int unsigned lead);
    logic [NR-1:0] m;
    m = '0;
    for (int r = 0; r < NR; r++) begin
      m[r] = row.vld[r] && (row.dst[r] == row.dst[lead]) && (row.mask[r] == row.mask[lead]);
    end
    return m & row.mask[lead];
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp == act) else begin
      errors++;
      $display("error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic add_row(input string name, input logic [NR-1:0] vld,
                         input logic [NR-1:0][IdWidth-1:0] dst, input logic [NR-1:0][NR-1:0] mask,
                         input logic [NR-1:0][1:0] opc, input int late_route,
                         input int late_delay, input int stall, input int outs);
    names[n_rows] = name;
    rows[n_rows]  = '{vld, dst, mask, opc, 4'(late_route), 4'(late_delay), 4'(stall), 4'(outs)};
    n_rows++;
  endtask

  task automatic build_table();
    add_row("add_full", 5'b11111, {NR{4'h9}}, {NR{5'b11111}}, {NR{RED_ADD}}, NoLate, 0, 0, 1);
    add_row("min_stall", 5'b11110, {NR{4'h3}}, {NR{5'b11110}}, {NR{RED_MIN}}, NoLate, 0, 3, 1);
    add_row("max_pair", 5'b00110, {NR{4'ha}}, {NR{5'b00110}}, {NR{RED_MAX}}, NoLate, 0, 0, 1);
    add_row("xor_full", 5'b11111, {NR{4'hc}}, {NR{5'b11111}}, {NR{RED_XOR}}, NoLate, 0, 0, 1);
    // Route 3 differs in mask, route 4 in destination
    add_row("filter", 5'b11110, {4'h8, 4'h3, 4'h3, 4'h3, 4'h3},
            {5'b10000, 5'b01000, 5'b00110, 5'b00110, 5'b00110},
            {RED_ADD, RED_XOR, RED_XOR, RED_XOR, RED_XOR}, NoLate, 0, 0, 3);
    add_row("late_west", 5'b11110, {NR{4'h2}}, {NR{5'b11110}}, {NR{RED_ADD}}, 4, 6, 0, 1);
    // Local target with eject in the mask but no eject flit
    add_row("loopback", 5'b00110, {NR{4'h5}}, {NR{5'b00111}}, {NR{RED_MAX}}, NoLate, 0, 0, 1);
    add_row("backpress", 5'b11111, {4'h9, 4'h9, 4'h9, 4'h6, 4'h6},
            {5'b11100, 5'b11100, 5'b11100, 5'b00011, 5'b00011},
            {RED_MIN, RED_MIN, RED_MIN, RED_ADD, RED_ADD}, NoLate, 0, 5, 2);
  endtask

  task automatic apply_reset();
    arst_n = 1'b0;
    rr_ptr = 0;
    repeat (2) @(posedge clk);
    #2 arst_n = 1'b1;
  endtask

  task automatic run_row(input int unsigned t);
    row_t                 row;
    logic [NR-1:0]        taken;
    logic [NR-1:0]        members;
    logic [DataWidth-1:0] held;
    int unsigned          cycle, stall_left, outs, late_wait, lead;
    logic                 late_pending, stalled, done;
    row = rows[t];
    for (int r = 0; r < NR; r++) begin
      rng          = xorshift(rng);
      payload[r]   = rng[DataWidth-1:0];
      dst_id[r]    = row.dst[r];
      coll_mask[r] = row.mask[r];
      op[r]        = red_op_e'(row.op[r]);
    end
    late_pending = (row.late_route < NR);
    valid        = row.vld;
    if (late_pending) begin
      valid[row.late_route] = 1'b0;
    end
    late_wait  = row.late_delay;
    stall_left = row.stall;
    out_ready  = (stall_left == 0);
    outs       = 0;
    cycle      = 0;
    stalled    = 1'b0;
    held       = '0;
    done       = 1'b0;
    while (!done && cycle < RowTimeout) begin
      // Sample mid-cycle, where handshakes for the next edge are settled
      @(negedge clk);
      cycle++;
      taken = ready & valid;
      if (late_pending) begin
        assert (!out_valid && taken == '0) else begin
          errors++;
          $display("%s: reduction went ahead before its last contributor was valid", names[t]);
        end
      end
      // Stalled output keeps its data and blocks the inputs
      if (out_valid && !out_ready) begin
        if (stalled) begin
          check_value({names[t], " held data"}, held, out_data);
        end
        check_value({names[t], " ready under stall"}, '0, taken);
        held       = out_data;
        stalled    = 1'b1;
        stall_left = (stall_left > 0) ? stall_left - 1 : 0;
      end else begin
        stalled = 1'b0;
      end
      // Output against the oldest consumed group
      if (out_valid) begin
        if (exp_data_q.size() == 0) begin
          assert (0) else begin
            errors++;
            $display("%s: an output appeared with no reduction consumed", names[t]);
          end
        end else begin
          check_value({names[t], " data"}, exp_data_q[0], out_data);
          check_value({names[t], " dst"}, exp_dst_q[0], out_dst_id);
          check_value({names[t], " op"}, exp_op_q[0], out_op);
          if (out_ready) begin
            void'(exp_data_q.pop_front());
            void'(exp_dst_q.pop_front());
            void'(exp_op_q.pop_front());
            outs++;
          end
        end
      end
      // A consumed set must be the whole group of the round-robin leader
      if (taken != '0) begin
        lead    = pick_leader(valid, rr_ptr);
        rr_ptr  = (lead + 1) % NR;
        members = group_of(row, lead);
        check_value({names[t], " consumed routes"}, members, taken);
        exp_data_q.push_back(reduce_payloads(members, red_op_e'(row.op[lead]), payload));
        exp_dst_q.push_back(row.dst[lead]);
        exp_op_q.push_back(red_op_e'(row.op[lead]));
      end
      done = ((valid & ~taken) == '0) && !late_pending && (exp_data_q.size() == 0);
      @(posedge clk);
      #2;
      valid = valid & ~taken;
      if (late_pending) begin
        if (late_wait == 0) begin
          valid[row.late_route] = 1'b1;
          late_pending          = 1'b0;
        end else begin
          late_wait--;
        end
      end
      out_ready = (stall_left == 0);
    end
    if (done) begin
      check_value({names[t], " output count"}, row.exp_outs, outs);
    end else begin
      errors++;
      $display("%s: timed out after %0d cycles waiting for the reduction", names[t], cycle);
      valid     = '0;
      out_ready = 1'b1;
      exp_data_q.delete();
      exp_dst_q.delete();
      exp_op_q.delete();
      apply_reset();
    end
  endtask

  initial begin
    arst_n    = 1'b0;
    valid     = '0;
    dst_id    = '0;
    coll_mask = '0;
    for (int r = 0; r < NR; r++) begin
      op[r] = RED_ADD;
    end
    payload   = '0;
    out_ready = 1'b0;
    rng       = 32'd40;
    errors    = 0;
    checks    = 0;
    n_rows    = 0;
    build_table();
    apply_reset();
    // Idle after reset with no valid inputs
    repeat (3) begin
      @(negedge clk);
      check_value("reset out_valid", 1'b0, out_valid);
      check_value("reset ready", '0, ready);
    end
    @(posedge clk);
    #2;
    for (int unsigned t = 0; t < n_rows; t++) begin
      run_row(t);
    end
    assert_fails = u_floo_reduction_unit.u_assertions.fail_count;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== floo_reduction_unit.f ====
design/floo_red_pkg.sv
design/floo_reduction_arbiter.sv
design/floo_reduction_sync.sv
design/floo_reduction_alu.sv
design/floo_reduction_ctrl.sv
design/floo_reduction_unit.sv
dv/floo_reduction_assertions.sv
dv/tb_floo_reduction_unit.sv

// ==== Bender.yml ====
package:
  name: floo_reduction_unit

sources:
  # Package first, then leaf blocks and the top level
  - design/floo_red_pkg.sv
  - design/floo_reduction_arbiter.sv
  - design/floo_reduction_sync.sv
  - design/floo_reduction_alu.sv
  - design/floo_reduction_ctrl.sv
  - design/floo_reduction_unit.sv

  - target: simulation
    files:
      - dv/floo_reduction_assertions.sv
      - dv/tb_floo_reduction_unit.sv
